/* verilog/riscv_pkg.sv */
package riscv_pkg;

    // One 32-bit instruction word as it comes back from the fetch memory.
    typedef logic [31:0] instr_t;

    // Major opcode field, bits 6:0 of an uncompressed instruction.
    typedef logic [6:0] opcode_t;

    localparam int unsigned OPCODE_LSB = 0;
    localparam int unsigned OPCODE_MSB = 6;

    // Conditional branches (BEQ, BNE, BLT, BGE, BLTU, BGEU).
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;

    // Unconditional jump with a PC relative offset.
    localparam opcode_t OPCODE_JAL = 7'b1101111;

    // Register indirect jump.
    localparam opcode_t OPCODE_JALR = 7'b1100111;

    /* A 32-bit instruction has both low bits set. Any other pattern in
     * bits 1:0 marks a 16-bit compressed instruction. */
    localparam logic [1:0] UNCOMPRESSED_MARK = 2'b11;

endpackage : riscv_pkg

/* verilog/frontend_pkg.sv */
package frontend_pkg;

    localparam int unsigned ADDR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    localparam addr_t RESET_PC   = 32'h0000_0000; // First fetch address after reset.
    localparam addr_t FETCH_STEP = 32'd4;         // Fetch always moves by one word.

    // Direct-mapped BTB; the index sits just above the word offset.
    localparam int unsigned BTB_ENTRIES   = 8;
    localparam int unsigned BTB_INDEX_LSB = 2;
    localparam int unsigned BTB_TAG_LSB   = BTB_INDEX_LSB + $clog2(BTB_ENTRIES);

    typedef logic [$clog2(BTB_ENTRIES)-1:0]  btb_index_t; // Address bits 4:2.
    typedef logic [ADDR_WIDTH-BTB_TAG_LSB-1:0] btb_tag_t; // Address bits 31:5.

    /* Two bit saturating counter. The upper half of the encoding
     * predicts taken. */
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_t;

    localparam int unsigned QUEUE_DEPTH = 4;

    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count_t; // Holds 0 to QUEUE_DEPTH.
    typedef logic [$clog2(QUEUE_DEPTH)-1:0]   queue_ptr_t;

endpackage : frontend_pkg

/* verilog/fetch_entry_if.sv */
`timescale 1ns/1ns

interface fetch_entry_if;
    import frontend_pkg::*;
    import riscv_pkg::*;

    logic   valid;
    logic   ready;
    addr_t  pc;          // Address the word was fetched from.
    instr_t instr;
    logic   speculative; // The fetch after this word followed a taken prediction.

    // The producer of an entry.
    modport source (
        output valid, pc, instr, speculative,
        input  ready
    );

    modport sink (
        input  valid, pc, instr, speculative,
        output ready
    );

endinterface : fetch_entry_if

/* verilog/branch_target_buffer.sv */
`timescale 1ns/1ns

module branch_target_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  frontend_pkg::addr_t lookup_pc_i,
    input  logic                update_i,
    input  frontend_pkg::addr_t update_pc_i,
    input  frontend_pkg::addr_t update_target_i,
    input  logic                update_taken_i,
    output logic                hit_o,
    output logic                predict_taken_o,
    output frontend_pkg::addr_t target_o
);
    import frontend_pkg::*;

    btb_tag_t               tag_q     [BTB_ENTRIES];
    addr_t                  target_q  [BTB_ENTRIES];
    counter_t               counter_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    btb_index_t lookup_index;
    btb_index_t update_index;
    btb_tag_t   lookup_tag;
    btb_tag_t   update_tag;
    logic       update_hit;
    counter_t   update_counter;

    assign lookup_index = lookup_pc_i[BTB_INDEX_LSB +: $bits(btb_index_t)];
    assign lookup_tag   = lookup_pc_i[BTB_TAG_LSB +: $bits(btb_tag_t)];
    assign update_index = update_pc_i[BTB_INDEX_LSB +: $bits(btb_index_t)];
    assign update_tag   = update_pc_i[BTB_TAG_LSB +: $bits(btb_tag_t)];

    assign hit_o           = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign predict_taken_o = counter_q[lookup_index] inside {CNT_WEAK_T, CNT_STRONG_T};
    assign target_o        = target_q[lookup_index];

    assign update_hit     = valid_q[update_index] && (tag_q[update_index] == update_tag);
    assign update_counter = counter_q[update_index];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                counter_q[i] <= CNT_STRONG_NT;
            end
        end else if (update_i) begin
            if (update_taken_i) begin
                valid_q[update_index] <= 1'b1;
                if (!update_hit) begin
                    counter_q[update_index] <= CNT_WEAK_T; // New entries start weakly taken.
                end else if (update_counter != CNT_STRONG_T) begin
                    counter_q[update_index] <= counter_t'(update_counter + 2'd1);
                end
            end else if (update_hit && (update_counter != CNT_STRONG_NT)) begin
                counter_q[update_index] <= counter_t'(update_counter - 2'd1);
            end
        end
    end

    // A taken outcome always refreshes the target, so a moved JALR target is learned.
    always_ff @(posedge clk_i) begin
        if (update_i && update_taken_i) begin
            tag_q[update_index]    <= update_tag;
            target_q[update_index] <= update_target_i;
        end
    end

endmodule : branch_target_buffer

/* verilog/pc_generator.sv */
`timescale 1ns/1ns

module pc_generator (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       exception_i,
    input  frontend_pkg::addr_t        handler_pc_i,
    input  logic                       executed_i,
    input  logic                       branch_i,
    input  logic                       jump_i,
    input  logic                       taken_i,
    input  logic                       speculative_i,
    input  frontend_pkg::addr_t        instr_address_i,
    input  frontend_pkg::addr_t        branch_target_addr_i,
    input  logic                       fetch_valid_i,
    input  riscv_pkg::instr_t          fetch_instruction_i,
    input  frontend_pkg::queue_count_t free_slots_i,
    output logic                       fetch_o,
    output frontend_pkg::addr_t        fetch_address_o,
    output logic                       flush_o,
    fetch_entry_if.source              entry
);
    import frontend_pkg::*;

    addr_t pc_q;             // Last address sent to the fetch memory.
    logic  predict_q;        // The BTB predicted taken for pc_q.
    addr_t predict_target_q;
    logic  inflight_q;       // A response is due in this cycle.
    logic  run_q;

    logic  outcome_taken;
    logic  mispredict;
    addr_t recovery_pc;
    logic  room;
    logic  btb_hit;
    logic  btb_taken;
    addr_t btb_target;

    assign outcome_taken = taken_i | jump_i;
    assign mispredict    = executed_i & (speculative_i != outcome_taken);
    assign recovery_pc   = outcome_taken ? branch_target_addr_i : instr_address_i + FETCH_STEP;
    assign flush_o       = exception_i | mispredict;

    // Every request must find a free slot when its response comes back.
    assign room    = free_slots_i > queue_count_t'(inflight_q);
    assign fetch_o = run_q & (flush_o | room);

    always_comb begin
        if (exception_i) begin
            fetch_address_o = handler_pc_i;
        end else if (mispredict) begin
            fetch_address_o = recovery_pc;
        end else if (predict_q) begin
            fetch_address_o = predict_target_q; // Follow the predicted branch.
        end else begin
            fetch_address_o = pc_q + FETCH_STEP;
        end
    end

    /* The lookup runs on the address being issued, so the prediction is
     * ready for the next request when the PC register takes the address. */
    branch_target_buffer btb_i (
        .clk_i           ( clk_i                             ),
        .rst_n_i         ( rst_n_i                           ),
        .lookup_pc_i     ( fetch_address_o                   ),
        .update_i        ( executed_i & (branch_i | jump_i)  ),
        .update_pc_i     ( instr_address_i                   ),
        .update_target_i ( branch_target_addr_i              ),
        .update_taken_i  ( outcome_taken                     ),
        .hit_o           ( btb_hit                           ),
        .predict_taken_o ( btb_taken                         ),
        .target_o        ( btb_target                        )
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q      <= 1'b0;
            inflight_q <= 1'b0;
            pc_q       <= RESET_PC - FETCH_STEP; // The first increment lands on RESET_PC.
            predict_q  <= 1'b0;
        end else begin
            run_q      <= 1'b1;
            inflight_q <= fetch_o;
            if (fetch_o) begin
                pc_q      <= fetch_address_o;
                predict_q <= btb_hit & btb_taken;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_o) begin
            predict_target_q <= btb_target;
        end
    end

    /* The memory answers one cycle after the request, so a response always
     * belongs to pc_q and carries the prediction made for it. */
    assign entry.valid       = fetch_valid_i & inflight_q & ~flush_o;
    assign entry.pc          = pc_q;
    assign entry.instr       = fetch_instruction_i;
    assign entry.speculative = predict_q;

endmodule : pc_generator

/* verilog/fetch_queue.sv */
`timescale 1ns/1ns

module fetch_queue (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    output frontend_pkg::queue_count_t free_slots_o,
    fetch_entry_if.sink                push,
    fetch_entry_if.source              pop
);
    import frontend_pkg::*;
    import riscv_pkg::*;

    addr_t                  pc_mem    [QUEUE_DEPTH];
    instr_t                 instr_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] spec_mem;

    queue_ptr_t   wr_ptr_q;
    queue_ptr_t   rd_ptr_q;
    queue_count_t count_q;
    logic         write;
    logic         read;

    assign write = push.valid;
    assign read  = pop.valid & pop.ready;

    assign free_slots_o = queue_count_t'(QUEUE_DEPTH) - count_q;

    assign pop.valid       = count_q != '0;
    assign pop.pc          = pc_mem[rd_ptr_q];
    assign pop.instr       = instr_mem[rd_ptr_q];
    assign pop.speculative = spec_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Pointers wrap at the power of two depth.
            end
            if (read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + queue_count_t'(write) - queue_count_t'(read);
        end
    end

    always_ff @(posedge clk_i) begin
        if (write) begin
            pc_mem[wr_ptr_q]    <= push.pc;
            instr_mem[wr_ptr_q] <= push.instr;
            spec_mem[wr_ptr_q]  <= push.speculative;
        end
    end

endmodule : fetch_queue

/* verilog/predecode_stage.sv */
`timescale 1ns/1ns

module predecode_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                issue_ready_i,
    output logic                issue_valid_o,
    output frontend_pkg::addr_t issue_pc_o,
    output riscv_pkg::instr_t   issue_instr_o,
    output logic                issue_compressed_o,
    output logic                issue_branch_o,
    output logic                issue_jump_o,
    output logic                issue_speculative_o,
    fetch_entry_if.sink         entry
);
    import riscv_pkg::*;

    opcode_t opcode;
    logic    compressed;
    logic    load;

    // The register frees up when it is empty or the backend takes its entry.
    assign entry.ready = ~issue_valid_o | issue_ready_i;
    assign load        = entry.valid & entry.ready;

    assign opcode     = entry.instr[OPCODE_MSB:OPCODE_LSB];
    assign compressed = entry.instr[1:0] != UNCOMPRESSED_MARK;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            issue_valid_o <= 1'b0;
        end else if (entry.ready) begin
            issue_valid_o <= entry.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            issue_pc_o          <= entry.pc;
            issue_instr_o       <= entry.instr;
            issue_speculative_o <= entry.speculative;
            issue_compressed_o  <= compressed;
            // A compressed word can carry any pattern in bits 6:2.
            issue_branch_o      <= ~compressed & (opcode == OPCODE_BRANCH);
            issue_jump_o        <= ~compressed & ((opcode == OPCODE_JAL) || (opcode == OPCODE_JALR));
        end
    end

endmodule : predecode_stage

/* verilog/frontend_top.sv */
`timescale 1ns/1ns

module frontend_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic                fetch_o,
    output frontend_pkg::addr_t fetch_address_o,
    input  logic                fetch_valid_i,
    input  riscv_pkg::instr_t   fetch_instruction_i,
    input  logic                exception_i,
    input  frontend_pkg::addr_t handler_pc_i,
    input  logic                executed_i,
    input  logic                branch_i,
    input  logic                jump_i,
    input  logic                taken_i,
    input  logic                speculative_i,
    input  frontend_pkg::addr_t instr_address_i,
    input  frontend_pkg::addr_t branch_target_addr_i,
    output logic                issue_valid_o,
    output frontend_pkg::addr_t issue_pc_o,
    output riscv_pkg::instr_t   issue_instr_o,
    output logic                issue_compressed_o,
    output logic                issue_branch_o,
    output logic                issue_jump_o,
    output logic                issue_speculative_o,
    input  logic                issue_ready_i
);
    import frontend_pkg::*;

    queue_count_t free_slots;
    logic         flush;

    fetch_entry_if fetch_entry ();  // Responses into the queue.
    fetch_entry_if queue_entry ();  // Queue head into predecode.

    pc_generator pc_generator_i (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .exception_i          ( exception_i          ),
        .handler_pc_i         ( handler_pc_i         ),
        .executed_i           ( executed_i           ),
        .branch_i             ( branch_i             ),
        .jump_i               ( jump_i               ),
        .taken_i              ( taken_i              ),
        .speculative_i        ( speculative_i        ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .fetch_valid_i        ( fetch_valid_i        ),
        .fetch_instruction_i  ( fetch_instruction_i  ),
        .free_slots_i         ( free_slots           ),
        .fetch_o              ( fetch_o              ),
        .fetch_address_o      ( fetch_address_o      ),
        .flush_o              ( flush                ),
        .entry                ( fetch_entry.source   )
    );

    fetch_queue fetch_queue_i (
        .clk_i        ( clk_i              ),
        .rst_n_i      ( rst_n_i            ),
        .flush_i      ( flush              ),
        .free_slots_o ( free_slots         ),
        .push         ( fetch_entry.sink   ),
        .pop          ( queue_entry.source )
    );

    predecode_stage predecode_stage_i (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .flush_i             ( flush               ),
        .issue_ready_i       ( issue_ready_i       ),
        .issue_valid_o       ( issue_valid_o       ),
        .issue_pc_o          ( issue_pc_o          ),
        .issue_instr_o       ( issue_instr_o       ),
        .issue_compressed_o  ( issue_compressed_o  ),
        .issue_branch_o      ( issue_branch_o      ),
        .issue_jump_o        ( issue_jump_o        ),
        .issue_speculative_o ( issue_speculative_o ),
        .entry               ( queue_entry.sink    )
    );

endmodule : frontend_top

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end
endmodule : tb_clock_gen

/* testbench/tb_frontend_chk.sv */
`timescale 1ns/1ns

module tb_frontend_chk (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        flush_i,
    input logic        valid_i,
    input logic        ready_i,
    input logic [67:0] data_i,
    input logic        write_i,
    input logic        full_i
);
    // A held entry keeps its valid and payload until the consumer takes it.
    hold_steady: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !ready_i && !flush_i |=> valid_i && $stable(data_i))
        else $error("held entry changed under back-pressure");

    no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_i |-> !full_i)
        else $error("queue written while full");

    valid_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
        else $error("valid raised during reset");
endmodule : tb_frontend_chk

bind predecode_stage tb_frontend_chk predecode_chk_i (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .valid_i ( issue_valid_o ),
    .ready_i ( issue_ready_i ),
    .data_i  ( {issue_pc_o, issue_instr_o, issue_compressed_o, issue_branch_o,
                issue_jump_o, issue_speculative_o} ),
    .write_i ( 1'b0 ),
    .full_i  ( 1'b0 )
);

bind fetch_queue tb_frontend_chk queue_chk_i (
    .clk_i,
    .rst_n_i,
    .flush_i,
    .valid_i ( 1'b0 ),
    .ready_i ( 1'b1 ),
    .data_i  ( '0 ),
    .write_i ( write ),
    .full_i  ( count_q == frontend_pkg::queue_count_t'(frontend_pkg::QUEUE_DEPTH) )
);

/* testbench/tb_frontend.sv */
`timescale 1ns/1ns

module tb_frontend;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

    logic        clk_i;
    logic        rst_n_i;
    logic        fetch_o;
    logic [31:0] fetch_address_o;
    logic        fetch_valid_i       = 1'b0;
    logic [31:0] fetch_instruction_i = '0;
    logic        exception_i, executed_i, branch_i, jump_i, taken_i, speculative_i;
    logic [31:0] handler_pc_i, instr_address_i, branch_target_addr_i;
    logic        issue_valid_o, issue_compressed_o, issue_branch_o, issue_jump_o;
    logic        issue_speculative_o, issue_ready_i;
    logic [31:0] issue_pc_o, issue_instr_o;

    // Reference model. Its BTB copy trains by the same counter rule as the DUT.
    logic        btb_valid  [8] = '{default: 1'b0};
    logic [26:0] btb_tag    [8] = '{default: '0};
    logic [31:0] btb_target [8] = '{default: '0};
    int          btb_count  [8] = '{default: 0};
    logic [31:0] expect_pc            = '0;
    logic        first_after_redirect = 1'b1; // Next issue is the redirect address itself.
    logic        first_predict        = 1'b0;
    logic [31:0] first_target         = '0;
    logic        fetch_started        = 1'b0;
    int          issued               = 0;
    int          drain_target;
    int          cycles               = 0;
    int unsigned seed;

    tb_clock_gen clock_gen_i (.clk_o(clk_i), .rst_n_o(rst_n_i));

    frontend_top frontend_top_i (.*);

    // Word hash over the whole address, with branch, JAL and compressed slots forced.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] word;
        word = (addr * 32'h9E37_79B1) ^ (addr >> 3) ^ 32'h5A5A_1234;
        case (addr[5:2])
            4'd3:    word[6:0] = 7'b1100011;
            4'd7:    word[6:0] = 7'b1101111;
            4'd11:   word[1:0] = 2'b01;
            default: ;
        endcase
        return word;
    endfunction

    function automatic logic [31:0] rand_addr();
        return {25'd0, 5'($urandom_range(31)), 2'b00};
    endfunction

    function automatic logic predicts_taken(input logic [31:0] addr);
        int idx;
        idx = int'(addr[4:2]);
        return btb_valid[idx] && (btb_tag[idx] == addr[31:5]) && (btb_count[idx] >= 2);
    endfunction

    task automatic train(input logic [31:0] addr, input logic [31:0] target, input logic taken);
        int   idx;
        logic hit;
        idx = int'(addr[4:2]);
        hit = btb_valid[idx] && (btb_tag[idx] == addr[31:5]);
        if (taken) begin
            btb_count[idx]  = !hit ? 2 : (btb_count[idx] == 3 ? 3 : btb_count[idx] + 1);
            btb_valid[idx]  = 1'b1;
            btb_tag[idx]    = addr[31:5];
            btb_target[idx] = target;
        end else if (hit && btb_count[idx] > 0) begin
            btb_count[idx] = btb_count[idx] - 1;
        end
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s actual %h expected %h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic drive_inputs(input logic allow_redirect);
        int   kind;
        logic taken;
        logic is_jump;
        kind    = allow_redirect ? int'($urandom_range(31)) : 31;
        taken   = $urandom_range(3) != 0;
        is_jump = $urandom_range(3) == 0;
        issue_ready_i        <= $urandom_range(9) < 7;
        handler_pc_i         <= rand_addr();
        instr_address_i      <= rand_addr();
        branch_target_addr_i <= rand_addr();
        branch_i             <= !is_jump;
        jump_i               <= is_jump;
        taken_i              <= taken;
        exception_i          <= (kind == 0) || (kind == 1);
        executed_i           <= (kind == 1) || (kind == 2);
        // Reports without an exception are always mispredictions, so each one redirects.
        speculative_i        <= (kind == 2) ? !(taken || is_jump) : 1'($urandom_range(1));
    endtask

    // Runs mid-cycle, when inputs and registered outputs are settled.
    task automatic observe_cycle();
        logic        outcome;
        logic        flush;
        logic        compressed;
        logic        is_branch;
        logic        is_jump;
        logic        pred;
        logic [31:0] word;
        logic [31:0] target;
        logic [31:0] redirect_pc;
        outcome = taken_i | jump_i;
        flush   = exception_i | (executed_i & (speculative_i != outcome));
        if (issue_valid_o && issue_ready_i && !flush) begin
            word       = mem_word(expect_pc);
            compressed = word[1:0] != 2'b11;
            is_branch  = !compressed && (word[6:0] == 7'b1100011);
            is_jump    = !compressed && (word[6:0] inside {7'b1101111, 7'b1100111});
            pred       = first_after_redirect ? first_predict : predicts_taken(expect_pc);
            target     = first_after_redirect ? first_target : btb_target[expect_pc[4:2]];
            check("issue_pc_o", issue_pc_o, expect_pc);
            check("issue_instr_o", issue_instr_o, word);
            check("issue_compressed_o", 32'(issue_compressed_o), 32'(compressed));
            check("issue_branch_o", 32'(issue_branch_o), 32'(is_branch));
            check("issue_jump_o", 32'(issue_jump_o), 32'(is_jump));
            check("issue_speculative_o", 32'(issue_speculative_o), 32'(pred));
            expect_pc            = pred ? target : expect_pc + 32'd4;
            first_after_redirect = 1'b0;
            issued++;
        end
        if (flush) begin
            redirect_pc = exception_i ? handler_pc_i :
                          (outcome ? branch_target_addr_i : instr_address_i + 32'd4);
            // The redirect address is looked up before the training edge.
            first_predict = predicts_taken(redirect_pc);
            first_target  = btb_target[redirect_pc[4:2]];
            if (executed_i) begin
                train(instr_address_i, branch_target_addr_i, outcome);
            end
            expect_pc            = redirect_pc;
            first_after_redirect = 1'b1;
        end
    endtask

    // The memory answers every request one cycle later.
    always @(posedge clk_i) begin
        fetch_valid_i       <= fetch_o;
        fetch_instruction_i <= mem_word(fetch_address_o);
    end

    // No request goes out in reset, and the first one after it reads address 0.
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            check("fetch_o", 32'(fetch_o), 32'd0);
        end else if (fetch_o && !fetch_started) begin
            check("fetch_address_o", fetch_address_o, 32'h0000_0000);
            fetch_started = 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            cycles <= cycles + 1;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timeout: the backend stopped receiving instructions");
                $display("Simulation failed");
                $fatal(1);
            end
        end
    end

    initial begin
        seed = $urandom(32'h4539);
        {exception_i, executed_i, branch_i, jump_i, taken_i, speculative_i} = '0;
        {handler_pc_i, instr_address_i, branch_target_addr_i} = '0;
        issue_ready_i = 1'b0;
        wait (rst_n_i === 1'b1);
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clk_i);
            drive_inputs(cyc >= 4); // No redirect while the generator starts up.
            @(negedge clk_i);
            observe_cycle();
        end
        drain_target = issued + 16;
        while (issued < drain_target) begin
            @(posedge clk_i);
            drive_inputs(1'b0);
            @(negedge clk_i);
            observe_cycle();
        end
        $display("Simulation completed successfully");
        $finish;
    end
endmodule : tb_frontend

/* all.f */
verilog/riscv_pkg.sv
verilog/frontend_pkg.sv
verilog/fetch_entry_if.sv
verilog/branch_target_buffer.sv
verilog/pc_generator.sv
verilog/fetch_queue.sv
verilog/predecode_stage.sv
verilog/frontend_top.sv
testbench/tb_clock_gen.sv
testbench/tb_frontend_chk.sv
testbench/tb_frontend.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_frontend
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
